//--- zxKeyPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZX keyboard shared definitions: slot map, matrix geometry,
// scan codes and the event, hotkey and key-state types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package zxKeyPkg;

	localparam int NumRows     = 8;   // Spectrum half-rows
	localparam int RowWidth    = 5;   // Keys per half-row
	localparam int RowAddrBase = 8;   // Address bit of row 0
	localparam int AddrWidth   = 16;

	localparam int NumSlots  = 104;  // Slot 0 unused
	localparam int SlotWidth = $clog2(NumSlots);

	typedef logic [NumSlots-1:0] keyState_t;  // One pressed bit per slot

	typedef struct packed {
		logic       keyDown;   // Press flag
		logic       extended;  // E0-prefixed code
		logic [7:0] code;
	} ps2Event_t;

	typedef struct packed {
		logic [10:0] fn;   // F11 down to F1
		logic [2:0]  mod;  // Ctrl, alt, shift
	} hotkeys_t;

	// Key slots, plain keys sit at their own scan code
	localparam logic [SlotWidth-1:0]
		SlotF9  = 7'h01, SlotF5   = 7'h03, SlotF3 = 7'h04, SlotF1 = 7'h05, SlotF2 = 7'h06,
		SlotF10 = 7'h09, SlotF8   = 7'h0A, SlotF6 = 7'h0B, SlotF4 = 7'h0C, SlotTab = 7'h0D,
		SlotVrtUnderscore = 7'h0F,
		SlotF7  = 7'h10, SlotLAlt = 7'h11, SlotLShift = 7'h12, SlotNum6 = 7'h13,
		SlotLCtrl = 7'h14, SlotQ = 7'h15, Slot1 = 7'h16, SlotVrtPlus = 7'h17,
		SlotF11 = 7'h18, SlotEsc  = 7'h19, SlotZ = 7'h1A, SlotS = 7'h1B, SlotA = 7'h1C,
		SlotW   = 7'h1D, Slot2    = 7'h1E, SlotVrtColon = 7'h1F,
		SlotNumStar = 7'h20, SlotC = 7'h21, SlotX = 7'h22, SlotD = 7'h23, SlotE = 7'h24,
		Slot4   = 7'h25, Slot3    = 7'h26, SlotVrtQuote = 7'h27, SlotNum2 = 7'h28,
		SlotSpace = 7'h29, SlotV  = 7'h2A, SlotF = 7'h2B, SlotT = 7'h2C, SlotR = 7'h2D,
		Slot5   = 7'h2E, SlotVrtLess = 7'h2F,
		SlotNumPlus = 7'h30, SlotN = 7'h31, SlotB = 7'h32, SlotH = 7'h33, SlotG = 7'h34,
		SlotY   = 7'h35, Slot6    = 7'h36, SlotVrtGreater = 7'h37, SlotRCtrl = 7'h38,
		SlotNum8 = 7'h39, SlotM   = 7'h3A, SlotJ = 7'h3B, SlotU = 7'h3C, Slot7 = 7'h3D,
		Slot8   = 7'h3E, SlotVrtQuestion = 7'h3F,
		SlotComma = 7'h41, SlotK  = 7'h42, SlotI = 7'h43, SlotO = 7'h44, Slot0 = 7'h45,
		Slot9   = 7'h46, SlotPeriod = 7'h49, SlotSlash = 7'h4A, SlotL = 7'h4B,
		SlotSemicolon = 7'h4C, SlotP = 7'h4D, SlotMinus = 7'h4E,
		SlotNumMinus = 7'h50, SlotQuote = 7'h52, SlotNum4 = 7'h53, SlotEquals = 7'h55,
		SlotRAlt = 7'h56, SlotCapsLock = 7'h58, SlotRShift = 7'h59, SlotEnter = 7'h5A,
		SlotHome = 7'h5C, SlotPgUp = 7'h5E, SlotPgDn = 7'h5F,
		SlotNumSlash = 7'h60, SlotLeft = 7'h61, SlotDown = 7'h62, SlotUp = 7'h63,
		SlotRight = 7'h64, SlotNumEnter = 7'h65, SlotBackspace = 7'h66, SlotEnd = 7'h67;

	// Scan codes that land away from their own slot
	localparam logic [7:0]
		CodeF7 = 8'h83, CodeF11 = 8'h78, CodeEsc = 8'h76,
		CodeNumPlus = 8'h79, CodeNumMinus = 8'h7B, CodeNumStar = 8'h7C,
		CodeAlt = 8'h11, CodeCtrl = 8'h14, CodeEnter = 8'h5A,  // Split on extended
		CodeLeft = 8'h6B, CodeDown = 8'h72, CodeUp = 8'h75, CodeRight = 8'h74,
		CodeEnd = 8'h69, CodeHome = 8'h6C, CodePgUp = 8'h7D, CodePgDn = 8'h7A,
		CodeMinus = 8'h4E, CodeEquals = 8'h55, CodeSemicolon = 8'h4C,
		CodeQuote = 8'h52, CodeComma = 8'h41, CodePeriod = 8'h49,
		CodeSlash = 8'h4A;  // Numpad / when extended

endpackage

`default_nettype wire

//--- ps2EventCapture.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PS/2 event capture: turns a toggle of the strobe bit into
// a one-cycle strobe with a registered key event
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ps2EventCapture (
	input  wire logic          clk_sys,
	input  wire logic          rstN,
	input  wire logic [10:0]   ps2Key,    // Toggle, press, extended, code
	output logic               strobe,    // One cycle per event
	output zxKeyPkg::ps2Event_t keyEvent
);

	logic toggleLast;  // Last seen toggle bit
	logic toggled;     // New event this cycle

	assign toggled = ps2Key[10] != toggleLast;

	always_ff @(posedge clk_sys) begin
		toggleLast <= ps2Key[10];  // Follows in reset too, no false event on exit
		if (!rstN) begin
			strobe <= 1'b0;
		end else begin
			strobe <= toggled;
		end
	end

	// Event payload, only meaningful with strobe
	always_ff @(posedge clk_sys) begin
		if (toggled) begin
			keyEvent <= zxKeyPkg::ps2Event_t'(ps2Key[9:0]);
		end
	end

endmodule

`default_nettype wire

//--- keyStateTracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Key state tracker: keeps the pressed bit of every key slot
// and latches Shift into the symbol slots at press time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module keyStateTracker (
	input  wire logic                clk_sys,
	input  wire logic                rstN,
	input  wire logic                strobe,
	input  wire zxKeyPkg::ps2Event_t keyEvent,
	output zxKeyPkg::keyState_t      state,
	output zxKeyPkg::hotkeys_t       hotkeys
);

	logic                            hit;        // Event maps to some slot
	logic                            isSymbol;   // Shift-latched symbol key
	logic [zxKeyPkg::SlotWidth-1:0]  slotPlain;  // Direct or unshifted slot
	logic [zxKeyPkg::SlotWidth-1:0]  slotVrt;    // Shifted virtual slot
	logic                            shiftHeld;
	logic                            altHeld;
	logic                            ctrlHeld;

	assign shiftHeld = state[zxKeyPkg::SlotLShift] | state[zxKeyPkg::SlotRShift];
	assign altHeld   = state[zxKeyPkg::SlotLAlt] | state[zxKeyPkg::SlotRAlt];
	assign ctrlHeld  = state[zxKeyPkg::SlotLCtrl] | state[zxKeyPkg::SlotRCtrl];

	// Scan code to slot decode
	always_comb begin
		hit       = 1'b1;
		isSymbol  = 1'b0;
		slotPlain = keyEvent.code[zxKeyPkg::SlotWidth-1:0];  // Plain keys keep their code
		slotVrt   = '0;
		case (keyEvent.code)
			zxKeyPkg::SlotF1, zxKeyPkg::SlotF2, zxKeyPkg::SlotF3, zxKeyPkg::SlotF4,
			zxKeyPkg::SlotF5, zxKeyPkg::SlotF6, zxKeyPkg::SlotF8, zxKeyPkg::SlotF9,
			zxKeyPkg::SlotF10, zxKeyPkg::SlotTab, zxKeyPkg::SlotCapsLock,
			zxKeyPkg::SlotBackspace, zxKeyPkg::SlotSpace,
			zxKeyPkg::SlotLShift, zxKeyPkg::SlotRShift,
			zxKeyPkg::SlotQ, zxKeyPkg::SlotW, zxKeyPkg::SlotE, zxKeyPkg::SlotR,
			zxKeyPkg::SlotT, zxKeyPkg::SlotY, zxKeyPkg::SlotU, zxKeyPkg::SlotI,
			zxKeyPkg::SlotO, zxKeyPkg::SlotP, zxKeyPkg::SlotA, zxKeyPkg::SlotS,
			zxKeyPkg::SlotD, zxKeyPkg::SlotF, zxKeyPkg::SlotG, zxKeyPkg::SlotH,
			zxKeyPkg::SlotJ, zxKeyPkg::SlotK, zxKeyPkg::SlotL, zxKeyPkg::SlotZ,
			zxKeyPkg::SlotX, zxKeyPkg::SlotC, zxKeyPkg::SlotV, zxKeyPkg::SlotB,
			zxKeyPkg::SlotN, zxKeyPkg::SlotM, zxKeyPkg::Slot0, zxKeyPkg::Slot1,
			zxKeyPkg::Slot2, zxKeyPkg::Slot3, zxKeyPkg::Slot4, zxKeyPkg::Slot5,
			zxKeyPkg::Slot6, zxKeyPkg::Slot7, zxKeyPkg::Slot8, zxKeyPkg::Slot9: ;

			// Codes above the slot range go to spare slots
			zxKeyPkg::CodeF7:       slotPlain = zxKeyPkg::SlotF7;
			zxKeyPkg::CodeF11:      slotPlain = zxKeyPkg::SlotF11;
			zxKeyPkg::CodeEsc:      slotPlain = zxKeyPkg::SlotEsc;
			zxKeyPkg::CodeNumPlus:  slotPlain = zxKeyPkg::SlotNumPlus;
			zxKeyPkg::CodeNumMinus: slotPlain = zxKeyPkg::SlotNumMinus;
			zxKeyPkg::CodeNumStar:  slotPlain = zxKeyPkg::SlotNumStar;

			// Right-hand or cursor twin on the extended flag
			zxKeyPkg::CodeAlt:
				slotPlain = keyEvent.extended ? zxKeyPkg::SlotRAlt : zxKeyPkg::SlotLAlt;
			zxKeyPkg::CodeCtrl:
				slotPlain = keyEvent.extended ? zxKeyPkg::SlotRCtrl : zxKeyPkg::SlotLCtrl;
			zxKeyPkg::CodeEnter:
				slotPlain = keyEvent.extended ? zxKeyPkg::SlotNumEnter : zxKeyPkg::SlotEnter;
			zxKeyPkg::CodeLeft:
				slotPlain = keyEvent.extended ? zxKeyPkg::SlotLeft : zxKeyPkg::SlotNum4;
			zxKeyPkg::CodeDown:
				slotPlain = keyEvent.extended ? zxKeyPkg::SlotDown : zxKeyPkg::SlotNum2;
			zxKeyPkg::CodeUp:
				slotPlain = keyEvent.extended ? zxKeyPkg::SlotUp : zxKeyPkg::SlotNum8;
			zxKeyPkg::CodeRight:
				slotPlain = keyEvent.extended ? zxKeyPkg::SlotRight : zxKeyPkg::SlotNum6;

			// Numpad versions left alone so the keypad cursors stay clean
			zxKeyPkg::CodeHome: begin
				hit       = keyEvent.extended;
				slotPlain = zxKeyPkg::SlotHome;
			end
			zxKeyPkg::CodeEnd: begin
				hit       = keyEvent.extended;
				slotPlain = zxKeyPkg::SlotEnd;
			end
			zxKeyPkg::CodePgUp: begin
				hit       = keyEvent.extended;
				slotPlain = zxKeyPkg::SlotPgUp;
			end
			zxKeyPkg::CodePgDn: begin
				hit       = keyEvent.extended;
				slotPlain = zxKeyPkg::SlotPgDn;
			end

			// Symbol keys, plain slot plus shifted virtual slot
			zxKeyPkg::CodeMinus: begin
				isSymbol = 1'b1;
				slotVrt  = zxKeyPkg::SlotVrtUnderscore;
			end
			zxKeyPkg::CodeEquals: begin
				isSymbol = 1'b1;
				slotVrt  = zxKeyPkg::SlotVrtPlus;
			end
			zxKeyPkg::CodeSemicolon: begin
				isSymbol = 1'b1;
				slotVrt  = zxKeyPkg::SlotVrtColon;
			end
			zxKeyPkg::CodeQuote: begin
				isSymbol = 1'b1;
				slotVrt  = zxKeyPkg::SlotVrtQuote;
			end
			zxKeyPkg::CodeComma: begin
				isSymbol = 1'b1;
				slotVrt  = zxKeyPkg::SlotVrtLess;
			end
			zxKeyPkg::CodePeriod: begin
				isSymbol = 1'b1;
				slotVrt  = zxKeyPkg::SlotVrtGreater;
			end
			zxKeyPkg::CodeSlash: begin
				if (keyEvent.extended) begin
					slotPlain = zxKeyPkg::SlotNumSlash;  // Numpad / is a plain SYMBOL key
				end else begin
					isSymbol = 1'b1;
					slotVrt  = zxKeyPkg::SlotVrtQuestion;
				end
			end
			default: hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rstN) begin
			state <= '0;
		end else if (strobe && hit) begin
			if (!isSymbol) begin
				state[slotPlain] <= keyEvent.keyDown;
			end else if (keyEvent.keyDown) begin
				state[shiftHeld ? slotVrt : slotPlain] <= 1'b1;  // Shift latched at press
			end else begin
				state[slotPlain] <= 1'b0;  // Release drops either meaning
				state[slotVrt]   <= 1'b0;
			end
		end
	end

	assign hotkeys.fn = {state[zxKeyPkg::SlotF11], state[zxKeyPkg::SlotF10],
		state[zxKeyPkg::SlotF9], state[zxKeyPkg::SlotF8], state[zxKeyPkg::SlotF7],
		state[zxKeyPkg::SlotF6], state[zxKeyPkg::SlotF5], state[zxKeyPkg::SlotF4],
		state[zxKeyPkg::SlotF3], state[zxKeyPkg::SlotF2], state[zxKeyPkg::SlotF1]};
	assign hotkeys.mod = {ctrlHeld, altHeld, shiftHeld};

endmodule

`default_nettype wire

//--- spectrumMatrix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Spectrum matrix: eight active-low half-rows from key state,
// merged for every row whose address line is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module spectrumMatrix (
	input  wire zxKeyPkg::keyState_t            state,
	input  wire logic [zxKeyPkg::AddrWidth-1:0] addr,
	output logic [zxKeyPkg::RowWidth-1:0]       keyData  // Active low
);

	logic [zxKeyPkg::NumRows-1:0][zxKeyPkg::RowWidth-1:0] rows;
	logic shiftAny;
	logic ctrlAny;
	logic capsAny;  // Keys wired to CAPS SHIFT
	logic symAny;   // Keys wired to SYMBOL SHIFT

	assign shiftAny = state[zxKeyPkg::SlotLShift] | state[zxKeyPkg::SlotRShift];
	assign ctrlAny  = state[zxKeyPkg::SlotLCtrl] | state[zxKeyPkg::SlotRCtrl];

	assign capsAny = state[zxKeyPkg::SlotNum6] | state[zxKeyPkg::SlotNum8]
		| state[zxKeyPkg::SlotNum2] | state[zxKeyPkg::SlotNum4] | state[zxKeyPkg::SlotTab]
		| state[zxKeyPkg::SlotEsc] | state[zxKeyPkg::SlotEnd] | state[zxKeyPkg::SlotRight]
		| state[zxKeyPkg::SlotUp] | state[zxKeyPkg::SlotDown] | state[zxKeyPkg::SlotLeft]
		| state[zxKeyPkg::SlotPgDn] | state[zxKeyPkg::SlotPgUp]
		| state[zxKeyPkg::SlotCapsLock] | state[zxKeyPkg::SlotHome]
		| state[zxKeyPkg::SlotBackspace];

	assign symAny = state[zxKeyPkg::SlotSlash] | state[zxKeyPkg::SlotPeriod]
		| state[zxKeyPkg::SlotComma] | state[zxKeyPkg::SlotQuote]
		| state[zxKeyPkg::SlotSemicolon] | state[zxKeyPkg::SlotEquals]
		| state[zxKeyPkg::SlotMinus] | state[zxKeyPkg::SlotNumPlus]
		| state[zxKeyPkg::SlotNumMinus] | state[zxKeyPkg::SlotNumStar]
		| state[zxKeyPkg::SlotNumSlash] | state[zxKeyPkg::SlotVrtQuestion]
		| state[zxKeyPkg::SlotVrtGreater] | state[zxKeyPkg::SlotVrtLess]
		| state[zxKeyPkg::SlotVrtQuote] | state[zxKeyPkg::SlotVrtColon]
		| state[zxKeyPkg::SlotVrtPlus] | state[zxKeyPkg::SlotVrtUnderscore];

	// CAPS SHIFT is suppressed while a symbol is held, so Shift+, reads as SS+R
	assign rows[0][0] = ~((shiftAny | capsAny) & ~symAny);
	assign rows[0][1] = ~(state[zxKeyPkg::SlotZ] | state[zxKeyPkg::SlotVrtColon]);
	assign rows[0][2] = ~state[zxKeyPkg::SlotX];
	assign rows[0][3] = ~(state[zxKeyPkg::SlotC] | state[zxKeyPkg::SlotVrtQuestion]);
	assign rows[0][4] = ~(state[zxKeyPkg::SlotV] | state[zxKeyPkg::SlotSlash]
		| state[zxKeyPkg::SlotNumSlash]);

	assign rows[1] = ~{state[zxKeyPkg::SlotG], state[zxKeyPkg::SlotF],
		state[zxKeyPkg::SlotD], state[zxKeyPkg::SlotS], state[zxKeyPkg::SlotA]};

	assign rows[2][0] = ~state[zxKeyPkg::SlotQ];
	assign rows[2][1] = ~state[zxKeyPkg::SlotW];
	assign rows[2][2] = ~state[zxKeyPkg::SlotE];
	assign rows[2][3] = ~(state[zxKeyPkg::SlotR] | state[zxKeyPkg::SlotVrtLess]);     // <
	assign rows[2][4] = ~(state[zxKeyPkg::SlotT] | state[zxKeyPkg::SlotVrtGreater]);  // >

	assign rows[3][0] = ~(state[zxKeyPkg::Slot1] | state[zxKeyPkg::SlotHome]);      // EDIT
	assign rows[3][1] = ~(state[zxKeyPkg::Slot2] | state[zxKeyPkg::SlotCapsLock]);
	assign rows[3][2] = ~(state[zxKeyPkg::Slot3] | state[zxKeyPkg::SlotPgUp]);      // TRUE VIDEO
	assign rows[3][3] = ~(state[zxKeyPkg::Slot4] | state[zxKeyPkg::SlotPgDn]);      // INV VIDEO
	assign rows[3][4] = ~(state[zxKeyPkg::Slot5] | state[zxKeyPkg::SlotLeft]
		| state[zxKeyPkg::SlotNum4]);

	assign rows[4][0] = ~(state[zxKeyPkg::Slot0] | state[zxKeyPkg::SlotVrtUnderscore]
		| state[zxKeyPkg::SlotBackspace]);  // DELETE
	assign rows[4][1] = ~(state[zxKeyPkg::Slot9] | state[zxKeyPkg::SlotEnd]);       // GRAPH
	assign rows[4][2] = ~(state[zxKeyPkg::Slot8] | state[zxKeyPkg::SlotRight]
		| state[zxKeyPkg::SlotNum6]);
	assign rows[4][3] = ~(state[zxKeyPkg::Slot7] | state[zxKeyPkg::SlotUp]
		| state[zxKeyPkg::SlotNum8] | state[zxKeyPkg::SlotQuote]);
	assign rows[4][4] = ~(state[zxKeyPkg::Slot6] | state[zxKeyPkg::SlotDown]
		| state[zxKeyPkg::SlotNum2]);

	assign rows[5][0] = ~(state[zxKeyPkg::SlotP] | state[zxKeyPkg::SlotVrtQuote]);  // Double quote
	assign rows[5][1] = ~(state[zxKeyPkg::SlotO] | state[zxKeyPkg::SlotSemicolon]);
	assign rows[5][2] = ~state[zxKeyPkg::SlotI];
	assign rows[5][3] = ~state[zxKeyPkg::SlotU];
	assign rows[5][4] = ~state[zxKeyPkg::SlotY];

	assign rows[6][0] = ~(state[zxKeyPkg::SlotEnter] | state[zxKeyPkg::SlotNumEnter]);
	assign rows[6][1] = ~(state[zxKeyPkg::SlotL] | state[zxKeyPkg::SlotEquals]);
	assign rows[6][2] = ~(state[zxKeyPkg::SlotK] | state[zxKeyPkg::SlotVrtPlus]
		| state[zxKeyPkg::SlotNumPlus]);
	assign rows[6][3] = ~(state[zxKeyPkg::SlotJ] | state[zxKeyPkg::SlotMinus]
		| state[zxKeyPkg::SlotNumMinus]);
	assign rows[6][4] = ~state[zxKeyPkg::SlotH];

	assign rows[7][0] = ~(state[zxKeyPkg::SlotSpace] | state[zxKeyPkg::SlotEsc]);  // BREAK
	assign rows[7][1] = ~(ctrlAny | symAny | state[zxKeyPkg::SlotTab]);  // Tab is EXTEND MODE
	assign rows[7][2] = ~(state[zxKeyPkg::SlotM] | state[zxKeyPkg::SlotPeriod]);
	assign rows[7][3] = ~(state[zxKeyPkg::SlotN] | state[zxKeyPkg::SlotComma]);
	assign rows[7][4] = ~(state[zxKeyPkg::SlotB] | state[zxKeyPkg::SlotNumStar]);

	// Every selected row pulls its keys low
	always_comb begin
		keyData = '1;
		for (int r = 0; r < zxKeyPkg::NumRows; r++) begin
			if (!addr[zxKeyPkg::RowAddrBase + r]) begin
				keyData = keyData & rows[r];
			end
		end
	end

endmodule

`default_nettype wire

//--- zxKeyboard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZX keyboard top: PS/2 events in, Spectrum rows and hotkeys out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module zxKeyboard (
	input  wire logic                           clk_sys,
	input  wire logic                           rstN,
	input  wire logic [10:0]                    ps2Key,
	input  wire logic [zxKeyPkg::AddrWidth-1:0] addr,
	output logic [zxKeyPkg::RowWidth-1:0]       keyData,  // Active low
	output zxKeyPkg::hotkeys_t                  hotkeys
);

	logic                strobe;
	zxKeyPkg::ps2Event_t keyEvent;
	zxKeyPkg::keyState_t keyState;

	ps2EventCapture uCapture (
		.clk_sys  (clk_sys),
		.rstN     (rstN),
		.ps2Key   (ps2Key),
		.strobe   (strobe),
		.keyEvent (keyEvent)
	);

	keyStateTracker uTracker (
		.clk_sys  (clk_sys),
		.rstN     (rstN),
		.strobe   (strobe),
		.keyEvent (keyEvent),
		.state    (keyState),
		.hotkeys  (hotkeys)
	);

	// Combinational, follows addr in the same cycle
	spectrumMatrix uMatrix (
		.state   (keyState),
		.addr    (addr),
		.keyData (keyData)
	);

endmodule

`default_nettype wire

//--- tbZxKeyboard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZX keyboard testbench: directed PS/2 events against a small
// key model, checking Spectrum rows and hotkeys
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tbZxKeyboard;

	typedef enum int {
		keyQ, keyA, keySpace, keyEnter, keyNumEnter, keyLeft, keyNum4, keyBackspace,
		keyLShift, keyComma, keyCommaLt, keyF1, keyF7, keyF11, keyLAlt, keyRAlt, keyCount
	} tbKey_t;

	logic               clk_sys;
	logic               rstN;
	logic [10:0]        ps2Key;
	logic [15:0]        addr;
	logic [4:0]         keyData;
	zxKeyPkg::hotkeys_t hotkeys;
	logic [keyCount-1:0] held;  // Model of keys down, comma split by latched Shift
	int                 errors;
	int                 checks;

	zxKeyboard dut (
		.clk_sys (clk_sys),
		.rstN    (rstN),
		.ps2Key  (ps2Key),
		.addr    (addr),
		.keyData (keyData),
		.hotkeys (hotkeys)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// PS/2 set 2 codes, bit 8 is the E0 prefix
	function automatic logic [8:0] scanCode(input tbKey_t k);
		case (k)
			keyQ:         return {1'b0, 8'h15};
			keyA:         return {1'b0, 8'h1C};
			keySpace:     return {1'b0, 8'h29};
			keyEnter:     return {1'b0, 8'h5A};
			keyNumEnter:  return {1'b1, 8'h5A};
			keyLeft:      return {1'b1, 8'h6B};
			keyNum4:      return {1'b0, 8'h6B};
			keyBackspace: return {1'b0, 8'h66};
			keyLShift:    return {1'b0, 8'h12};
			keyComma:     return {1'b0, 8'h41};
			keyF1:        return {1'b0, 8'h05};
			keyF7:        return {1'b0, 8'h83};
			keyF11:       return {1'b0, 8'h78};
			keyLAlt:      return {1'b0, 8'h11};
			keyRAlt:      return {1'b1, 8'h11};
			default:      return 9'h000;
		endcase
	endfunction

	// Expected half-row, active low
	function automatic logic [4:0] expectRow(input int r);
		logic [4:0] on;
		logic       sym;
		on  = '0;
		sym = held[keyComma] | held[keyCommaLt];
		case (r)
			0: on[0] = (held[keyLShift] | held[keyLeft] | held[keyNum4] | held[keyBackspace])
				& ~sym;  // Symbol wins over CAPS
			1: on[0] = held[keyA];
			2: begin
				on[0] = held[keyQ];
				on[3] = held[keyCommaLt];  // < sits on R
			end
			3: on[4] = held[keyLeft] | held[keyNum4];
			4: on[0] = held[keyBackspace];  // DELETE is CAPS+0
			6: on[0] = held[keyEnter] | held[keyNumEnter];
			7: begin
				on[0] = held[keySpace];
				on[1] = sym;
				on[3] = held[keyComma];  // Comma sits on N
			end
			default: on = '0;
		endcase
		return ~on;
	endfunction

	function automatic logic [4:0] mergedRows(input logic [15:0] a);
		logic [4:0] d;
		d = '1;
		for (int r = 0; r < zxKeyPkg::NumRows; r++) begin
			if (!a[zxKeyPkg::RowAddrBase + r]) begin
				d = d & expectRow(r);
			end
		end
		return d;
	endfunction

	function automatic zxKeyPkg::hotkeys_t hotkeyModel();
		zxKeyPkg::hotkeys_t h;
		h        = '0;
		h.fn[0]  = held[keyF1];
		h.fn[6]  = held[keyF7];
		h.fn[10] = held[keyF11];
		h.mod[1] = held[keyLAlt] | held[keyRAlt];
		h.mod[0] = held[keyLShift];
		return h;
	endfunction

	// One event, then three edges for capture and tracker
	task automatic sendKey(input tbKey_t k, input logic down);
		logic [8:0] sc;
		sc = scanCode(k);
		@(posedge clk_sys);
		ps2Key <= {~ps2Key[10], down, sc};
		if (k == keyComma && !down) begin
			held[keyComma]   = 1'b0;  // Release drops both meanings
			held[keyCommaLt] = 1'b0;
		end else if (k == keyComma) begin
			held[held[keyLShift] ? keyCommaLt : keyComma] = 1'b1;
		end else begin
			held[k] = down;
		end
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic checkAddr(input logic [15:0] a);
		logic [4:0]         expData;
		zxKeyPkg::hotkeys_t expHot;
		@(posedge clk_sys);
		addr <= a;
		@(negedge clk_sys);  // Sample away from the drive edge
		expData = mergedRows(a);
		expHot  = hotkeyModel();
		checks++;
		assert (keyData === expData) else begin
			errors++;
			$display("FAIL %0t: keyData %b, expected %b at addr %h", $time, keyData, expData, a);
		end
		assert (hotkeys === expHot) else begin
			errors++;
			$display("FAIL %0t: hotkeys %h, expected %h", $time, hotkeys, expHot);
		end
	endtask

	// Each row on its own, then all rows at once
	task automatic scanRows();
		for (int r = 0; r < zxKeyPkg::NumRows; r++) begin
			checkAddr(~(16'h0001 << (zxKeyPkg::RowAddrBase + r)));
		end
		checkAddr(16'h0000);
	endtask

	task automatic idleAfterReset();
		for (int i = 0; i < 16; i++) begin
			checkAddr(~(16'h0001 << i));
		end
		checkAddr(16'h0000);
	endtask

	task automatic plainKeys();
		tbKey_t keys [4];
		keys = '{keyQ, keySpace, keyEnter, keyNumEnter};
		foreach (keys[i]) begin
			sendKey(keys[i], 1'b1);
			scanRows();
			sendKey(keys[i], 1'b0);
			scanRows();
		end
	endtask

	task automatic capsWiredKeys();
		sendKey(keyLeft, 1'b1);
		scanRows();
		sendKey(keyLeft, 1'b0);
		scanRows();
		sendKey(keyNum4, 1'b1);
		scanRows();
		sendKey(keyLeft, 1'b1);
		scanRows();
		sendKey(keyLeft, 1'b0);  // Num4 still holds the bits
		scanRows();
		sendKey(keyNum4, 1'b0);
		scanRows();
		sendKey(keyBackspace, 1'b1);
		scanRows();
		sendKey(keyBackspace, 1'b0);
		scanRows();
	endtask

	task automatic symbolShiftLatch();
		sendKey(keyLShift, 1'b1);
		scanRows();
		sendKey(keyComma, 1'b1);  // Latches as <
		scanRows();
		sendKey(keyLShift, 1'b0);
		scanRows();
		sendKey(keyComma, 1'b0);
		scanRows();
	endtask

	task automatic addrMerge();
		sendKey(keyQ, 1'b1);
		checkAddr(16'hF9FF);  // Row 2 alone pulls bit 0
		sendKey(keyA, 1'b1);
		checkAddr(16'hF9FF);  // Rows 1 and 2
		scanRows();
		sendKey(keyQ, 1'b0);
		checkAddr(16'hF9FF);  // Row 1 alone pulls bit 0
		sendKey(keyA, 1'b0);
		scanRows();
	endtask

	task automatic hotkeyBits();
		tbKey_t keys [3];
		keys = '{keyF1, keyF7, keyF11};
		foreach (keys[i]) begin
			sendKey(keys[i], 1'b1);
			checkAddr(16'h0000);
		end
		foreach (keys[i]) begin
			sendKey(keys[i], 1'b0);
			checkAddr(16'h0000);
		end
		sendKey(keyLAlt, 1'b1);
		checkAddr(16'h0000);
		sendKey(keyRAlt, 1'b1);
		checkAddr(16'h0000);
		sendKey(keyLAlt, 1'b0);  // Right Alt keeps mod bit 1
		checkAddr(16'h0000);
		sendKey(keyRAlt, 1'b0);
		checkAddr(16'h0000);
	endtask

	// Budget from event, scan and single-check counts
	initial begin : watchdog
		int numSends;
		int numScans;
		int numSingles;
		int budget;
		numSends   = 34;
		numScans   = 22;
		numSingles = 30;
		budget     = 2 + numSends * 4 + numScans * 9 + numSingles + 200;
		repeat (budget) @(posedge clk_sys);
		$display("Timeout: tests did not finish within %0d cycles", budget);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		rstN   = 1'b0;
		ps2Key = '0;
		addr   = '1;
		held   = '0;
		errors = 0;
		checks = 0;
		repeat (2) @(posedge clk_sys);
		rstN <= 1'b1;
		idleAfterReset();
		plainKeys();
		capsWiredKeys();
		symbolShiftLatch();
		addrMerge();
		hotkeyBits();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
zxKeyPkg.sv
ps2EventCapture.sv
keyStateTracker.sv
spectrumMatrix.sv
zxKeyboard.sv
tbZxKeyboard.sv

//--- run.sh
#!/bin/sh
# Build and run the ZX keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tbZxKeyboard \
	-f project.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
